/* mcu_pkg.sv */
package mcu_pkg;

    // --------------------
    // memory sizes
    // --------------------
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;
    localparam int HOST_AW   = 12;
    localparam int DADDR_W   = 24;

    // --------------------
    // host register map
    // --------------------
    // word addresses, bit 11 clear
    localparam logic [HOST_AW-1:0] REG_ID        = 12'h000;
    localparam logic [HOST_AW-1:0] REG_VERSION   = 12'h001;
    localparam logic [HOST_AW-1:0] REG_MEM_SIZE  = 12'h002;
    localparam logic [HOST_AW-1:0] REG_CTL_RESET = 12'h004;
    localparam logic [HOST_AW-1:0] REG_STATUS    = 12'h005;

    localparam logic [31:0] CORE_ID_VALUE      = 32'h4d43_5501;
    localparam logic [31:0] CORE_VERSION_VALUE = 32'h0001_0000;

    // core held in reset after system reset
    localparam logic CTL_RESET_INIT = 1'b1;

    // --------------------
    // data address regions
    // --------------------
    // compared against address bits 23:20
    localparam logic [3:0] REGION_RAM  = 4'h0;
    localparam logic [3:0] REGION_EXT  = 4'he;
    localparam logic [3:0] REGION_MMIO = 4'hf;

    // --------------------
    // instruction set
    // --------------------
    typedef enum logic [7:0] {
        OP_HALT = 8'h00,
        OP_LDI  = 8'h01,
        OP_ADDI = 8'h02,
        OP_LD   = 8'h03,
        OP_ST   = 8'h04,
        OP_JNZ  = 8'h05
    } opcode_e;

    typedef struct packed {
        opcode_e              opcode;
        logic [DADDR_W-1:0]   addr;
    } insn_mem_t;

    typedef struct packed {
        opcode_e              opcode;
        logic [23:0]          imm;
    } insn_imm_t;

    // same word, addressed or immediate form
    typedef union packed {
        insn_mem_t mem_view;
        insn_imm_t imm_view;
    } mcu_insn_u;

    // --------------------
    // bus bundles
    // --------------------
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [DADDR_W-1:0]   addr;
        logic [31:0]          wdata;
    } dbus_req_t;

    typedef struct packed {
        logic                 done;
        logic [31:0]          rdata;
    } dbus_rsp_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [HOST_AW-1:0]   adr;
        logic [31:0]          dat;
        logic [3:0]           sel;
    } host_wb_req_t;

endpackage

/* mcu_host_port.sv */
`timescale 1ns/1ps

module mcu_host_port import mcu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  host_wb_req_t       host_req_i,
    output logic [31:0]        host_dat_o,
    output logic               host_ack_o,
    output logic               core_reset_o,
    input  logic               halted_i,
    input  logic [RAM_AW-1:0]  pc_i,
    output logic               ram_a_en_o,
    output logic [3:0]         ram_a_we_o,
    output logic [RAM_AW-1:0]  ram_a_addr_o,
    output logic [31:0]        ram_a_wdata_o,
    input  logic [31:0]        ram_a_rdata_i,
    input  logic [RAM_AW-1:0]  fetch_addr_i,
    output logic               fetch_grant_o
);

    logic        host_req;
    logic        host_ram;
    logic        host_reg;
    logic        ack_q;
    logic        ctl_reset_q;
    logic        core_reset_q;
    logic        ram_sel_q;
    logic [31:0] reg_rdata;
    logic [31:0] reg_rdata_q;

    // new access, not yet acked
    assign host_req = host_req_i.cyc && host_req_i.stb && !ack_q;
    assign host_ram = host_req && host_req_i.adr[HOST_AW-1];
    assign host_reg = host_req && !host_req_i.adr[HOST_AW-1];

    always_comb begin
        case (host_req_i.adr)
            REG_ID:        reg_rdata = CORE_ID_VALUE;
            REG_VERSION:   reg_rdata = CORE_VERSION_VALUE;
            REG_MEM_SIZE:  reg_rdata = 32'(RAM_WORDS);
            REG_CTL_RESET: reg_rdata = {31'b0, ctl_reset_q};
            // halted in bit 0, pc in 25:16
            REG_STATUS:    reg_rdata = {6'b0, pc_i, 15'b0, halted_i};
            default:       reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q        <= 1'b0;
            ctl_reset_q  <= CTL_RESET_INIT;
            core_reset_q <= 1'b1;
        end else begin
            ack_q        <= host_req;
            core_reset_q <= ctl_reset_q;
            if (host_reg && host_req_i.we && host_req_i.adr == REG_CTL_RESET &&
                host_req_i.sel[0]) begin
                ctl_reset_q <= host_req_i.dat[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_req) begin
            ram_sel_q   <= host_ram;
            reg_rdata_q <= reg_rdata;
        end
    end

    assign host_ack_o   = ack_q;
    assign host_dat_o   = ram_sel_q ? ram_a_rdata_i : reg_rdata_q;
    assign core_reset_o = core_reset_q;

    // --------------------
    // port A arbitration
    // --------------------
    // host wins, fetch waits for the grant
    assign fetch_grant_o = !host_ram;
    assign ram_a_en_o    = host_ram || !core_reset_q;
    assign ram_a_we_o    = (host_ram && host_req_i.we) ? host_req_i.sel : 4'b0000;
    assign ram_a_addr_o  = host_ram ? host_req_i.adr[RAM_AW-1:0] : fetch_addr_i;
    assign ram_a_wdata_o = host_req_i.dat;

endmodule

/* mcu_core.sv */
`timescale 1ns/1ps

module mcu_core import mcu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    output logic [RAM_AW-1:0]  fetch_addr_o,
    input  logic               fetch_grant_i,
    input  mcu_insn_u          fetch_data_i,
    output dbus_req_t          dbus_req_o,
    input  dbus_rsp_t          dbus_rsp_i,
    output logic               halted_o,
    output logic [RAM_AW-1:0]  pc_o
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } state_e;

    state_e              state_q;
    logic [RAM_AW-1:0]   pc_q;
    logic [RAM_AW-1:0]   pc_inc;
    logic [31:0]         acc_q;
    logic [31:0]         imm_sext;
    logic                req_valid_q;
    logic                req_write_q;
    logic [DADDR_W-1:0]  req_addr_q;
    logic [31:0]         req_wdata_q;

    assign pc_inc   = pc_q + RAM_AW'(1);
    assign imm_sext = {{8{fetch_data_i.imm_view.imm[23]}}, fetch_data_i.imm_view.imm};

    // --------------------
    // sequencer
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= FETCH;
            pc_q        <= '0;
            acc_q       <= '0;
            req_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FETCH: begin
                    // port A may be busy with the host
                    if (fetch_grant_i) begin
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    case (fetch_data_i.imm_view.opcode)
                        OP_LDI: begin
                            acc_q   <= imm_sext;
                            pc_q    <= pc_inc;
                            state_q <= FETCH;
                        end
                        OP_ADDI: begin
                            acc_q   <= acc_q + imm_sext;
                            pc_q    <= pc_inc;
                            state_q <= FETCH;
                        end
                        OP_LD, OP_ST: begin
                            req_valid_q <= 1'b1;
                            pc_q        <= pc_inc;
                            state_q     <= MEM;
                        end
                        OP_JNZ: begin
                            if (acc_q != '0) begin
                                pc_q <= fetch_data_i.imm_view.imm[RAM_AW-1:0];
                            end else begin
                                pc_q <= pc_inc;
                            end
                            state_q <= FETCH;
                        end
                        // HALT and unknown opcodes
                        default: begin
                            state_q <= HALTED;
                        end
                    endcase
                end
                MEM: begin
                    if (dbus_rsp_i.done) begin
                        req_valid_q <= 1'b0;
                        if (!req_write_q) begin
                            acc_q <= dbus_rsp_i.rdata;
                        end
                        state_q <= FETCH;
                    end
                end
                default: begin
                    // stays halted until reset
                    state_q <= HALTED;
                end
            endcase
        end
    end

    // --------------------
    // data request payload
    // --------------------
    always_ff @(posedge clk) begin
        if (state_q == EXEC) begin
            req_write_q <= (fetch_data_i.mem_view.opcode == OP_ST);
            req_addr_q  <= fetch_data_i.mem_view.addr;
            req_wdata_q <= acc_q;
        end
    end

    assign dbus_req_o.valid = req_valid_q;
    assign dbus_req_o.write = req_write_q;
    assign dbus_req_o.addr  = req_addr_q;
    assign dbus_req_o.wdata = req_wdata_q;

    assign fetch_addr_o = pc_q;
    assign pc_o         = pc_q;
    assign halted_o     = (state_q == HALTED);

endmodule

/* mcu_ram.sv */
`timescale 1ns/1ps

module mcu_ram import mcu_pkg::*; (
    input  logic               clk,
    input  logic               a_en_i,
    input  logic [3:0]         a_we_i,
    input  logic [RAM_AW-1:0]  a_addr_i,
    input  logic [31:0]        a_wdata_i,
    output logic [31:0]        a_rdata_o,
    input  logic               b_en_i,
    input  logic               b_we_i,
    input  logic [RAM_AW-1:0]  b_addr_i,
    input  logic [31:0]        b_wdata_i,
    output logic [31:0]        b_rdata_o
);

    logic [31:0] mem [RAM_WORDS];

    // port A, byte lanes, write-first
    always @(posedge clk) begin
        if (a_en_i) begin
            for (int i = 0; i < 4; i++) begin
                if (a_we_i[i]) begin
                    mem[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
                    a_rdata_o[8*i +: 8]     <= a_wdata_i[8*i +: 8];
                end else begin
                    a_rdata_o[8*i +: 8]     <= mem[a_addr_i][8*i +: 8];
                end
            end
        end
    end

    // port B, whole words
    always @(posedge clk) begin
        if (b_en_i) begin
            if (b_we_i) begin
                mem[b_addr_i] <= b_wdata_i;
                b_rdata_o     <= b_wdata_i;
            end else begin
                b_rdata_o     <= mem[b_addr_i];
            end
        end
    end

endmodule

/* mcu_dbus_decode.sv */
`timescale 1ns/1ps

module mcu_dbus_decode import mcu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  dbus_req_t          dbus_req_i,
    output dbus_rsp_t          dbus_rsp_o,
    output logic               b_en_o,
    output logic               b_we_o,
    output logic [RAM_AW-1:0]  b_addr_o,
    output logic [31:0]        b_wdata_o,
    input  logic [31:0]        b_rdata_i,
    output logic               m_cyc_o,
    output logic               m_stb_o,
    output logic               m_we_o,
    output logic [19:0]        m_adr_o,
    output logic [31:0]        m_dat_o,
    input  logic [31:0]        m_dat_i,
    input  logic               m_ack_i,
    output logic               mmio_wr_o,
    output logic               mmio_rd_o,
    output logic [19:0]        mmio_addr_o,
    output logic [31:0]        mmio_wdata_o,
    input  logic [31:0]        mmio_rdata_i
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_EXT,
        DEC_RESP
    } dec_state_e;

    dec_state_e   state_q;
    logic [3:0]   region;
    logic [3:0]   region_q;
    logic         start;
    logic         cyc_q;
    logic [31:0]  ext_rdata_q;

    assign region = dbus_req_i.addr[DADDR_W-1:DADDR_W-4];
    // first cycle of an access
    assign start  = (state_q == DEC_IDLE) && dbus_req_i.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= DEC_IDLE;
            cyc_q   <= 1'b0;
        end else begin
            case (state_q)
                DEC_IDLE: begin
                    if (dbus_req_i.valid) begin
                        if (region == REGION_EXT) begin
                            cyc_q   <= 1'b1;
                            state_q <= DEC_EXT;
                        end else begin
                            state_q <= DEC_RESP;
                        end
                    end
                end
                DEC_EXT: begin
                    if (m_ack_i) begin
                        cyc_q   <= 1'b0;
                        state_q <= DEC_RESP;
                    end
                end
                default: begin
                    state_q <= DEC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            region_q <= region;
        end
        if (state_q == DEC_EXT && m_ack_i) begin
            ext_rdata_q <= m_dat_i;
        end
    end

    // --------------------
    // region ports
    // --------------------
    assign b_en_o    = start && (region == REGION_RAM);
    assign b_we_o    = b_en_o && dbus_req_i.write;
    assign b_addr_o  = dbus_req_i.addr[RAM_AW-1:0];
    assign b_wdata_o = dbus_req_i.wdata;

    assign m_cyc_o = cyc_q;
    assign m_stb_o = cyc_q;
    assign m_we_o  = cyc_q && dbus_req_i.write;
    assign m_adr_o = dbus_req_i.addr[19:0];
    assign m_dat_o = dbus_req_i.wdata;

    assign mmio_wr_o    = start && (region == REGION_MMIO) && dbus_req_i.write;
    assign mmio_rd_o    = start && (region == REGION_MMIO) && !dbus_req_i.write;
    assign mmio_addr_o  = dbus_req_i.addr[19:0];
    assign mmio_wdata_o = dbus_req_i.wdata;

    // read return by registered region
    always_comb begin
        dbus_rsp_o.done = (state_q == DEC_RESP);
        case (region_q)
            REGION_RAM:  dbus_rsp_o.rdata = b_rdata_i;
            REGION_EXT:  dbus_rsp_o.rdata = ext_rdata_q;
            REGION_MMIO: dbus_rsp_o.rdata = mmio_rdata_i;
            default:     dbus_rsp_o.rdata = '0;
        endcase
    end

endmodule

/* mcu_top.sv */
`timescale 1ns/1ps

module mcu_top import mcu_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  host_wb_req_t   host_req_i,
    output logic [31:0]    host_dat_o,
    output logic           host_ack_o,
    output logic           m_cyc_o,
    output logic           m_stb_o,
    output logic           m_we_o,
    output logic [19:0]    m_adr_o,
    output logic [31:0]    m_dat_o,
    input  logic [31:0]    m_dat_i,
    input  logic           m_ack_i,
    output logic           mmio_wr_o,
    output logic           mmio_rd_o,
    output logic [19:0]    mmio_addr_o,
    output logic [31:0]    mmio_wdata_o,
    input  logic [31:0]    mmio_rdata_i
);

    logic               core_reset;
    logic               halted;
    logic [RAM_AW-1:0]  pc;
    logic [RAM_AW-1:0]  fetch_addr;
    logic               fetch_grant;

    logic               ram_a_en;
    logic [3:0]         ram_a_we;
    logic [RAM_AW-1:0]  ram_a_addr;
    logic [31:0]        ram_a_wdata;
    logic [31:0]        ram_a_rdata;

    logic               ram_b_en;
    logic               ram_b_we;
    logic [RAM_AW-1:0]  ram_b_addr;
    logic [31:0]        ram_b_wdata;
    logic [31:0]        ram_b_rdata;

    dbus_req_t          dbus_req;
    dbus_rsp_t          dbus_rsp;

    mcu_host_port mcu_host_port_i (
        .clk           (clk),
        .reset         (reset),
        .host_req_i    (host_req_i),
        .host_dat_o    (host_dat_o),
        .host_ack_o    (host_ack_o),
        .core_reset_o  (core_reset),
        .halted_i      (halted),
        .pc_i          (pc),
        .ram_a_en_o    (ram_a_en),
        .ram_a_we_o    (ram_a_we),
        .ram_a_addr_o  (ram_a_addr),
        .ram_a_wdata_o (ram_a_wdata),
        .ram_a_rdata_i (ram_a_rdata),
        .fetch_addr_i  (fetch_addr),
        .fetch_grant_o (fetch_grant)
    );

    // core runs under the host-controlled reset
    mcu_core mcu_core_i (
        .clk           (clk),
        .reset         (core_reset),
        .fetch_addr_o  (fetch_addr),
        .fetch_grant_i (fetch_grant),
        .fetch_data_i  (ram_a_rdata),
        .dbus_req_o    (dbus_req),
        .dbus_rsp_i    (dbus_rsp),
        .halted_o      (halted),
        .pc_o          (pc)
    );

    mcu_ram mcu_ram_i (
        .clk       (clk),
        .a_en_i    (ram_a_en),
        .a_we_i    (ram_a_we),
        .a_addr_i  (ram_a_addr),
        .a_wdata_i (ram_a_wdata),
        .a_rdata_o (ram_a_rdata),
        .b_en_i    (ram_b_en),
        .b_we_i    (ram_b_we),
        .b_addr_i  (ram_b_addr),
        .b_wdata_i (ram_b_wdata),
        .b_rdata_o (ram_b_rdata)
    );

    mcu_dbus_decode mcu_dbus_decode_i (
        .clk          (clk),
        .reset        (reset),
        .dbus_req_i   (dbus_req),
        .dbus_rsp_o   (dbus_rsp),
        .b_en_o       (ram_b_en),
        .b_we_o       (ram_b_we),
        .b_addr_o     (ram_b_addr),
        .b_wdata_o    (ram_b_wdata),
        .b_rdata_i    (ram_b_rdata),
        .m_cyc_o      (m_cyc_o),
        .m_stb_o      (m_stb_o),
        .m_we_o       (m_we_o),
        .m_adr_o      (m_adr_o),
        .m_dat_o      (m_dat_o),
        .m_dat_i      (m_dat_i),
        .m_ack_i      (m_ack_i),
        .mmio_wr_o    (mmio_wr_o),
        .mmio_rd_o    (mmio_rd_o),
        .mmio_addr_o  (mmio_addr_o),
        .mmio_wdata_o (mmio_wdata_o),
        .mmio_rdata_i (mmio_rdata_i)
    );

endmodule

/* tb_mcu_top.sv */
`timescale 1ns/1ps

module tb_mcu_top import mcu_pkg::*; ();

    typedef struct packed {
        logic [19:0] adr;
        logic [31:0] dat;
    } bus_wr_t;

    localparam int HOST_TIMEOUT = 20;
    localparam int POLL_LIMIT   = 300;
    localparam int MODEL_STEPS  = 2000;

    logic          clk = 1'b0;
    logic          reset;
    host_wb_req_t  host_req;
    logic [31:0]   host_dat;
    logic          host_ack;
    logic          m_cyc;
    logic          m_stb;
    logic          m_we;
    logic [19:0]   m_adr;
    logic [31:0]   m_wdata;
    logic [31:0]   m_rdata = '0;
    logic          m_ack = 1'b0;
    logic          mmio_wr;
    logic          mmio_rd;
    logic [19:0]   mmio_addr;
    logic [31:0]   mmio_wdata;
    logic [31:0]   mmio_rdata = '0;

    // host-side image of the RAM and the reference copies
    logic [31:0]   ram_img [RAM_WORDS];
    logic [31:0]   model_ram [RAM_WORDS];
    logic [31:0]   ext_mem [logic [19:0]];
    logic [31:0]   model_ext [logic [19:0]];
    bus_wr_t       exp_ext[$];
    bus_wr_t       exp_mmio[$];
    bus_wr_t       ext_log[$];
    bus_wr_t       mmio_log[$];
    logic [RAM_AW-1:0] model_pc;
    int            wait_q[$];
    int            ws_left;
    logic          ext_busy;
    bus_wr_t       ext_got;
    bus_wr_t       mmio_got;

    mcu_top mcu_top_i (
        .clk          (clk),
        .reset        (reset),
        .host_req_i   (host_req),
        .host_dat_o   (host_dat),
        .host_ack_o   (host_ack),
        .m_cyc_o      (m_cyc),
        .m_stb_o      (m_stb),
        .m_we_o       (m_we),
        .m_adr_o      (m_adr),
        .m_dat_o      (m_wdata),
        .m_dat_i      (m_rdata),
        .m_ack_i      (m_ack),
        .mmio_wr_o    (mmio_wr),
        .mmio_rd_o    (mmio_rd),
        .mmio_addr_o  (mmio_addr),
        .mmio_wdata_o (mmio_wdata),
        .mmio_rdata_i (mmio_rdata)
    );

    always #20 clk = ~clk;

    // --------------------
    // helpers and checks
    // --------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_ext_access(input string what, input bus_wr_t got, input bus_wr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t ns: %s got adr %h dat %h, expected adr %h dat %h",
                               $time, what, got.adr, got.dat, exp.adr, exp.dat));
        end
    endtask

    task automatic check_status(input string what, input logic [31:0] status,
                                input logic exp_halted, input logic [RAM_AW-1:0] exp_pc);
        if (status[0] !== exp_halted || status[25:16] !== exp_pc) begin
            stop_run($sformatf("[FAIL] %0t ns: %s status halted %b pc %h, expected %b pc %h",
                               $time, what, status[0], status[25:16], exp_halted, exp_pc));
        end
    endtask

    function automatic logic [31:0] ext_fill(input logic [19:0] adr);
        return {adr[11:0], adr} ^ 32'h5a00_0000;
    endfunction

    function automatic logic [31:0] mmio_value(input logic [19:0] adr);
        return {adr, adr[19:8]} ^ 32'h0f0f_1234;
    endfunction

    function automatic logic [31:0] encode_insn(input opcode_e op, input logic [23:0] field);
        mcu_insn_u w;
        w.imm_view.opcode = op;
        w.imm_view.imm    = field;
        return w;
    endfunction

    function automatic logic [HOST_AW-1:0] ram_host_adr(input logic [RAM_AW-1:0] a);
        return {1'b1, 1'b0, a};
    endfunction

    // ISA interpreter over the model copies, 1 when HALT is reached
    function automatic bit run_model();
        logic [RAM_AW-1:0] pc;
        logic [31:0]       acc;
        logic [31:0]       word;
        logic [31:0]       imm;
        logic [23:0]       addr;
        logic [3:0]        region;
        bus_wr_t           wr;
        exp_ext.delete();
        exp_mmio.delete();
        pc  = '0;
        acc = '0;
        for (int step = 0; step < MODEL_STEPS; step++) begin
            word   = model_ram[pc];
            imm    = {{8{word[23]}}, word[23:0]};
            addr   = word[23:0];
            region = addr[23:20];
            wr.adr = addr[19:0];
            wr.dat = acc;
            case (word[31:24])
                OP_LDI:  acc = imm;
                OP_ADDI: acc = acc + imm;
                OP_LD: begin
                    if (region == REGION_RAM) begin
                        acc = model_ram[addr[RAM_AW-1:0]];
                    end else if (region == REGION_EXT) begin
                        acc = model_ext.exists(wr.adr) ? model_ext[wr.adr] : ext_fill(wr.adr);
                    end else if (region == REGION_MMIO) begin
                        acc = mmio_value(wr.adr);
                    end else begin
                        acc = '0;
                    end
                end
                OP_ST: begin
                    if (region == REGION_RAM) begin
                        model_ram[addr[RAM_AW-1:0]] = acc;
                    end else if (region == REGION_EXT) begin
                        model_ext[wr.adr] = acc;
                        exp_ext.push_back(wr);
                    end else if (region == REGION_MMIO) begin
                        exp_mmio.push_back(wr);
                    end
                end
                OP_JNZ: begin
                end
                default: begin
                    model_pc = pc;
                    return 1'b1;
                end
            endcase
            if (word[31:24] == OP_JNZ && acc != '0) begin
                pc = imm[RAM_AW-1:0];
            end else begin
                pc = pc + 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // --------------------
    // host driver
    // --------------------
    task automatic host_access(input logic we, input logic [HOST_AW-1:0] adr,
                               input logic [31:0] dat, input logic [3:0] sel,
                               output logic [31:0] rdata);
        host_wb_req_t req;
        int           cycles;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        @(posedge clk);
        host_req <= req;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > HOST_TIMEOUT) begin
                stop_run($sformatf("timeout: no host ack for address %h", adr));
            end
        end while (!host_ack);
        rdata = host_dat;
        host_req <= '0;
    endtask

    task automatic host_write(input logic [HOST_AW-1:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [31:0] unused;
        host_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic host_read(input logic [HOST_AW-1:0] adr, output logic [31:0] dat);
        host_access(1'b0, adr, '0, 4'hf, dat);
    endtask

    // RAM write that also merges into the image
    task automatic load_word(input logic [RAM_AW-1:0] a, input logic [31:0] dat,
                             input logic [3:0] sel);
        host_write(ram_host_adr(a), dat, sel);
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                ram_img[a][8*i +: 8] = dat[8*i +: 8];
            end
        end
    endtask

    task automatic load_program(input logic [31:0] words[$]);
        for (int i = 0; i < words.size(); i++) begin
            load_word(RAM_AW'(i), words[i], 4'hf);
        end
    endtask

    // release the core, wait for HALTED and compare with the model
    task automatic run_program(input string name, input logic [RAM_AW-1:0] addrs[$]);
        logic [31:0] st;
        logic [31:0] rd;
        int          polls;
        model_ram = ram_img;
        model_ext = ext_mem;
        ext_log.delete();
        mmio_log.delete();
        if (!run_model()) begin
            stop_run($sformatf("reference model of %s never reached HALT", name));
        end
        host_write(REG_CTL_RESET, 32'h0, 4'hf);
        polls = 0;
        do begin
            host_read(REG_STATUS, st);
            polls++;
            if (polls > POLL_LIMIT) begin
                stop_run($sformatf("timeout: %s never showed HALTED in STATUS", name));
            end
        end while (!st[0]);
        check_status(name, st, 1'b1, model_pc);
        foreach (addrs[i]) begin
            host_read(ram_host_adr(addrs[i]), rd);
            check_word($sformatf("%s RAM word %h", name, addrs[i]), rd, model_ram[addrs[i]]);
        end
        check_word({name, " Wishbone write count"}, 32'(ext_log.size()), 32'(exp_ext.size()));
        check_word({name, " MMIO write count"}, 32'(mmio_log.size()), 32'(exp_mmio.size()));
        ram_img = model_ram;
    endtask

    // --------------------
    // bus models
    // --------------------
    always @(posedge clk) begin
        if (reset) begin
            m_ack    <= 1'b0;
            ext_busy = 1'b0;
        end else if (m_ack) begin
            m_ack    <= 1'b0;
            ext_busy = 1'b0;
        end else if (m_cyc && m_stb) begin
            if (!ext_busy) begin
                ext_busy = 1'b1;
                ws_left  = (wait_q.size() > 0) ? wait_q.pop_front() : 0;
            end
            if (ws_left > 0) begin
                ws_left--;
            end else begin
                m_ack <= 1'b1;
                if (m_we) begin
                    ext_mem[m_adr] = m_wdata;
                    ext_got.adr    = m_adr;
                    ext_got.dat    = m_wdata;
                    if (ext_log.size() >= exp_ext.size()) begin
                        stop_run($sformatf("[FAIL] %0t ns: unexpected Wishbone write to %h",
                                           $time, m_adr));
                    end else begin
                        check_ext_access("Wishbone write", ext_got, exp_ext[ext_log.size()]);
                        ext_log.push_back(ext_got);
                    end
                end else begin
                    m_rdata <= ext_mem.exists(m_adr) ? ext_mem[m_adr] : ext_fill(m_adr);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (mmio_rd) begin
            mmio_rdata <= mmio_value(mmio_addr);
        end
        if (mmio_wr) begin
            mmio_got.adr = mmio_addr;
            mmio_got.dat = mmio_wdata;
            if (mmio_log.size() >= exp_mmio.size()) begin
                stop_run($sformatf("[FAIL] %0t ns: unexpected MMIO write to %h",
                                   $time, mmio_addr));
            end else begin
                check_ext_access("MMIO write", mmio_got, exp_mmio[mmio_log.size()]);
                mmio_log.push_back(mmio_got);
            end
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] first_sum;
        logic [31:0] s0;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [3:0]  sel;
        logic [23:0] k;
        logic [23:0] v;
        logic [23:0] a;
        logic [23:0] b;
        logic [31:0] prog_a[$];
        logic [31:0] prog_b[$];
        logic [31:0] prog_c[$];
        int          n;
        void'($urandom(28405));
        reset    = 1'b1;
        host_req = '0;
        for (int i = 0; i < 256; i++) begin
            wait_q.push_back($urandom_range(5, 0));
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // identification and reset state
        host_read(REG_ID, rd);
        check_word("ID register", rd, CORE_ID_VALUE);
        host_read(REG_VERSION, rd);
        check_word("VERSION register", rd, CORE_VERSION_VALUE);
        host_read(REG_MEM_SIZE, rd);
        check_word("MEM_SIZE register", rd, 32'(RAM_WORDS));
        host_read(REG_CTL_RESET, rd);
        check_word("CTL_RESET register", rd, 32'h1);
        host_read(REG_STATUS, rd);
        check_status("after reset", rd, 1'b0, '0);

        // byte-merged RAM writes
        for (int i = 0; i < 4; i++) begin
            d0  = $urandom;
            d1  = $urandom;
            sel = 4'($urandom_range(15, 0));
            load_word(RAM_AW'(10'h300 + i), d0, 4'hf);
            load_word(RAM_AW'(10'h300 + i), d1, sel);
            host_read(ram_host_adr(RAM_AW'(10'h300 + i)), rd);
            check_word("byte-merged RAM word", rd, ram_img[10'h300 + i]);
        end

        // counting loop into RAM
        n  = $urandom_range(6, 2);
        k  = 24'($urandom);
        v  = 24'($urandom);
        s0 = $urandom;
        prog_a = {encode_insn(OP_LDI, 24'(n)), encode_insn(OP_ST, 24'h000100),
                  encode_insn(OP_LD, 24'h000101), encode_insn(OP_ADDI, k),
                  encode_insn(OP_ST, 24'h000101), encode_insn(OP_LD, 24'h000100),
                  encode_insn(OP_ADDI, 24'hffffff), encode_insn(OP_JNZ, 24'h000001),
                  encode_insn(OP_LDI, v), encode_insn(OP_ST, 24'h000102),
                  encode_insn(OP_HALT, 24'h0)};
        load_program(prog_a);
        load_word(10'h100, 32'h0, 4'hf);
        load_word(10'h101, s0, 4'hf);
        load_word(10'h102, 32'h0, 4'hf);
        run_program("loop program", {10'h100, 10'h101, 10'h102});
        // n passes, each adding the sign-extended k
        first_sum = s0 + 32'(n) * {{8{k[23]}}, k};

        // external Wishbone region
        a = 24'($urandom);
        b = 24'($urandom);
        prog_b = {encode_insn(OP_LDI, a), encode_insn(OP_ST, 24'he00010),
                  encode_insn(OP_ADDI, b), encode_insn(OP_ST, 24'he00011),
                  encode_insn(OP_LD, 24'he00010), encode_insn(OP_ST, 24'h000110),
                  encode_insn(OP_LD, 24'he00345), encode_insn(OP_ST, 24'h000111),
                  encode_insn(OP_ST, 24'he00020), encode_insn(OP_HALT, 24'h0)};
        host_write(REG_CTL_RESET, 32'h1, 4'hf);
        load_program(prog_b);
        run_program("Wishbone program", {10'h110, 10'h111});

        // MMIO region and an unmapped region
        prog_c = {encode_insn(OP_LDI, a), encode_insn(OP_ST, 24'hf00004),
                  encode_insn(OP_LD, 24'hf00008), encode_insn(OP_ST, 24'h000120),
                  encode_insn(OP_ADDI, b), encode_insn(OP_ST, 24'hf0000c),
                  encode_insn(OP_LD, 24'hf00abc), encode_insn(OP_ST, 24'h000121),
                  encode_insn(OP_ST, 24'h700000), encode_insn(OP_LD, 24'h500000),
                  encode_insn(OP_ST, 24'h000122), encode_insn(OP_HALT, 24'h0)};
        host_write(REG_CTL_RESET, 32'h1, 4'hf);
        load_program(prog_c);
        run_program("MMIO program", {10'h120, 10'h121, 10'h122});

        // core reset through CTL_RESET, loop program again
        host_write(REG_CTL_RESET, 32'h1, 4'hf);
        host_read(REG_STATUS, rd);
        check_status("core held in reset", rd, 1'b0, '0);
        load_program(prog_a);
        load_word(10'h100, 32'h0, 4'hf);
        load_word(10'h101, s0, 4'hf);
        load_word(10'h102, 32'h0, 4'hf);
        run_program("loop program rerun", {10'h100, 10'h101, 10'h102});
        host_read(ram_host_adr(10'h101), rd);
        check_word("loop sum after restart", rd, first_sum);

        $display("test passed");
        $finish;
    end

endmodule

/* mcu_top.f */
mcu_pkg.sv
mcu_host_port.sv
mcu_core.sv
mcu_ram.sv
mcu_dbus_decode.sv
mcu_top.sv
tb_mcu_top.sv

/* Bender.yml */
package:
  name: mcu_top

sources:
  - mcu_pkg.sv
  - mcu_host_port.sv
  - mcu_core.sv
  - mcu_ram.sv
  - mcu_dbus_decode.sv
  - mcu_top.sv
  - target: test
    files:
      - tb_mcu_top.sv
